/* Makefile */
TOP = tb_zx_bus_core
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f zx_bus_core.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "no pass line in log"; exit 1)

lint:
	verilator --lint-only --timing --assert -f zx_bus_core.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* source/bank_regs.sv */
// Paging registers behind the 7FFD, 1FFD and EFF7 ports
// The machine type is sampled while reset is high and held until the next reset
// I/O write strobes must stay low for two clocks or more so the edge is seen
// A register write shows one clock after the write level first goes high
module bank_regs
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [MACH_W-1:0]     machine,
	input  logic [ADDR_W-1:0]     addr,
	input  logic [DATA_W-1:0]     cpu_dout,
	input  logic                  iorq_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	output logic [MACH_W-1:0]     machine_q,
	output logic [RAM_PAGE_W-1:0] ram_page,
	output logic [ROM_SEL_W-1:0]  rom_sel,
	output logic                  special_mode,
	output logic [1:0]            special_cfg,
	output logic                  screen_page
);

	page7ffd_u         page_reg;
	page7ffd_u         wr_data;
	logic [DATA_W-1:0] page_reg_plus3;
	logic [DATA_W-1:0] page_reg_p1024;
	logic [2:0]        page_ext;
	logic              io_wr;
	logic              old_wr;
	logic              wr_edge;
	logic              zx48;
	logic              plus3;
	logic              p1024;
	logic              page_disable;
	logic              sel_7ffd;
	logic              sel_1ffd;
	logic              sel_eff7;

	assign io_wr   = ~iorq_n & ~wr_n & m1_n;
	assign wr_edge = io_wr & ~old_wr;
	assign wr_data = cpu_dout;

	assign zx48  = (machine_q == MACH_ZX48);
	assign plus3 = (machine_q == MACH_PLUS3);
	assign p1024 = (machine_q == MACH_P1024);

	// Bit 5 is a bank bit on the Pentagon until EFF7 bit 2 restores the lock
	assign page_disable = zx48 | (~p1024 & page_reg.std.lock) |
		(p1024 & page_reg_p1024[2] & page_reg.std.lock);

	// ========================================
	// Port decode
	// ========================================
	assign sel_7ffd = plus3 ? ((addr & PORT_7FFD_MASK_P3) == PORT_7FFD_MATCH_P3) :
		((addr & PORT_7FFD_MASK) == PORT_7FFD_MATCH);
	assign sel_1ffd = plus3 & ((addr & PORT_1FFD_MASK) == PORT_1FFD_MATCH);
	assign sel_eff7 = p1024 & ((addr & PORT_EFF7_MASK) == PORT_EFF7_MATCH);

	always_ff @(posedge clk_sys) begin
		old_wr <= io_wr;
		if (reset) begin
			old_wr         <= 1'b0;
			machine_q      <= machine;
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_reg_p1024 <= '0;
			page_ext       <= '0;
		end else if (wr_edge) begin
			if (sel_7ffd & ~page_disable) begin
				page_reg <= wr_data;
				// Extended bank bits load from 5, 7, 6 in 1024K mode
				if (p1024 & ~page_reg_p1024[2]) begin
					page_ext <= {wr_data.p1024.ext_lo, wr_data.p1024.ext_hi};
				end
			end else if (sel_1ffd & ~page_disable) begin
				page_reg_plus3 <= cpu_dout;
			end
			if (sel_eff7) begin
				page_reg_p1024 <= cpu_dout;
			end
		end
	end

	// ========================================
	// Outputs to the memory map
	// ========================================
	assign ram_page     = {page_ext, page_reg.std.bank};
	assign screen_page  = page_reg.std.screen;
	assign special_mode = page_reg_plus3[0];
	assign special_cfg  = page_reg_plus3[2:1];

	always_comb begin
		case (machine_q)
			MACH_ZX48:  rom_sel = '0;
			MACH_PLUS3: rom_sel = {page_reg_plus3[2], page_reg.std.rom};
			default:    rom_sel = {1'b0, page_reg.std.rom};
		endcase
	end

	// 1FFD only ever latches on the +3
	a_plus3_only: assert property (@(posedge clk_sys) disable iff (reset)
		!plus3 |-> (page_reg_plus3 == '0))
		else $error("1FFD register changed on a non +3 machine");

	// Banks above 7 exist only on the Pentagon 1024
	a_ext_p1024_only: assert property (@(posedge clk_sys) disable iff (reset)
		!p1024 |-> (page_ext == '0))
		else $error("extended bank bits set outside Pentagon 1024 mode");

endmodule

/* source/mem_map.sv */
// Maps the CPU address and paging state onto the 21-bit memory address
// Purely combinational, so ram_addr and ram_we follow the bus in the same cycle
// Writes into the ROM area are dropped
module mem_map
	import zx_pkg::*;
(
	input  logic [ADDR_W-1:0]     addr,
	input  logic                  mreq_n,
	input  logic                  wr_n,
	input  logic [RAM_PAGE_W-1:0] ram_page,
	input  logic [ROM_SEL_W-1:0]  rom_sel,
	input  logic                  special_mode,
	input  logic [1:0]            special_cfg,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we
);

	logic [1:0]            slot;
	logic [BANK_OFS_W-1:0] ofs;
	logic [RAM_PAGE_W-1:0] bank;
	logic                  rom_area;

	// 16 KB slot number and offset within it
	assign slot = addr[ADDR_W-1 -: 2];
	assign ofs  = addr[BANK_OFS_W-1:0];

	always_comb begin
		rom_area = 1'b0;
		bank     = '0;
		if (special_mode) begin
			// +3 all-RAM layouts
			case (special_cfg)
				2'd0: bank = {4'b0000, slot};
				2'd1: bank = {3'b000, 1'b1, slot};
				2'd2: bank = (slot == 2'd3) ? 6'd3 : {3'b000, 1'b1, slot};
				default: begin
					case (slot)
						2'd1:    bank = 6'd7;
						2'd3:    bank = 6'd3;
						default: bank = {3'b000, 1'b1, slot};
					endcase
				end
			endcase
		end else begin
			case (slot)
				2'd0:    rom_area = 1'b1;
				2'd1:    bank = 6'd5;
				2'd2:    bank = 6'd2;
				default: bank = ram_page;
			endcase
		end

		if (rom_area) begin
			ram_addr = {1'b1, {(RAM_PAGE_W - ROM_SEL_W){1'b0}}, rom_sel, ofs};
		end else begin
			ram_addr = {1'b0, bank, ofs};
		end

		ram_we = ~mreq_n & ~wr_n & ~rom_area;

		// Slot 0 in normal mode is ROM and takes no write strobe
		a_no_rom_write: assert (!(ram_we && !special_mode && slot == 2'd0))
			else $error("memory write into ROM area at %h", ram_addr);
	end

endmodule

/* source/ula_ports.sv */
// ULA port FE, joystick emulation, Kempston port and the CPU read-data mux
// The FE latch updates on every clock of an FE write
// cpu_din is combinational and reads FF while no strobe is active
// key_data is active low, joystick inputs are active high
module ula_ports
	import zx_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic              mreq_n,
	input  logic [DATA_W-1:0] ram_dout,
	input  logic [KEY_W-1:0]  key_data,
	input  logic              tape_in,
	input  logic [2:0]        joy_mode,
	input  logic [JOY_W-1:0]  joystick_0,
	input  logic [JOY_W-1:0]  joystick_1,
	output logic [DATA_W-1:0] cpu_din,
	output logic [2:0]        border_color,
	output logic              ear_out,
	output logic              mic_out
);

	logic             io_wr;
	logic             io_rd;
	logic             kemp_mode;
	logic             s1_mode;
	logic             s2_mode;
	logic             cur_mode;
	logic [JOY_W-1:0] joy_any;
	logic [KEY_W-1:0] row_67890;
	logic [KEY_W-1:0] row_12345;
	logic [KEY_W-1:0] joy_keys;
	logic             ear_in;

	assign io_wr = ~iorq_n & ~wr_n & m1_n;
	assign io_rd = ~iorq_n & ~rd_n & m1_n;

	// ========================================
	// FE write latch
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr & ~addr[0]) begin
			border_color <= cpu_dout[2:0];
			mic_out      <= cpu_dout[3];
			ear_out      <= cpu_dout[4];
		end
	end

	// ========================================
	// Joystick to keyboard
	// ========================================
	assign kemp_mode = (joy_mode == JOY_KEMPSTON);
	assign s1_mode   = (joy_mode == JOY_SINCLAIR1) | (joy_mode == JOY_SINCLAIR12);
	assign s2_mode   = (joy_mode == JOY_SINCLAIR2) | (joy_mode == JOY_SINCLAIR12);
	assign cur_mode  = (joy_mode == JOY_CURSOR);
	assign joy_any   = joystick_0 | joystick_1;

	// Half row 6-7-8-9-0, key 0 in bit 0
	// Sinclair I gives left 6, right 7, down 8, up 9, fire 0
	// Cursor gives down 6, up 7, right 8, fire 0
	assign row_67890 =
		({KEY_W{s1_mode}} & {joystick_0[1], joystick_0[0], joystick_0[2],
			joystick_0[3], joystick_0[4]}) |
		({KEY_W{cur_mode}} & {joy_any[2], joy_any[3], joy_any[0], 1'b0, joy_any[4]});

	// Half row 1-2-3-4-5, key 1 in bit 0
	// Cursor only adds left on key 5
	assign row_12345 =
		({KEY_W{s2_mode}} & {joystick_1[4], joystick_1[3], joystick_1[2],
			joystick_1[0], joystick_1[1]}) |
		({KEY_W{cur_mode}} & {joy_any[1], 4'b0000});

	// Rows are selected by A12 and A11 low
	assign joy_keys = ({KEY_W{~addr[12]}} & row_67890) | ({KEY_W{~addr[11]}} & row_12345);

	assign ear_in = tape_in | ear_out;

	// ========================================
	// Read data mux
	// ========================================
	always_comb begin
		if (~mreq_n) begin
			cpu_din = ram_dout;
		end else if (io_rd & ~addr[0]) begin
			cpu_din = {1'b1, ear_in, 1'b1, key_data & ~joy_keys};
		end else if (io_rd & kemp_mode & (addr[5:0] == PORT_KEMPSTON)) begin
			cpu_din = {{(DATA_W - JOY_W){1'b0}}, joy_any};
		end else begin
			cpu_din = 8'hFF;
		end
	end

endmodule

/* source/zx_bus_core.sv */
// Memory and I/O decoding core of a Spectrum-family machine
// The CPU bus enters as plain strobes, there is no wait or back-pressure
// The memory behind ram_addr is outside, with ram_dout returned combinationally
module zx_bus_core
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [ADDR_W-1:0]     addr,
	input  logic [DATA_W-1:0]     cpu_dout,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  logic [MACH_W-1:0]     machine,
	input  logic [2:0]            joy_mode,
	input  logic [JOY_W-1:0]      joystick_0,
	input  logic [JOY_W-1:0]      joystick_1,
	input  logic [KEY_W-1:0]      key_data,
	input  logic                  tape_in,
	input  logic [DATA_W-1:0]     ram_dout,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	output logic [DATA_W-1:0]     cpu_din,
	output logic                  screen_page,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic [RAM_PAGE_W-1:0] ram_page;
	logic [ROM_SEL_W-1:0]  rom_sel;
	logic                  special_mode;
	logic [1:0]            special_cfg;

	bank_regs u_bank_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.iorq_n       (iorq_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.machine_q    (),
		.ram_page     (ram_page),
		.rom_sel      (rom_sel),
		.special_mode (special_mode),
		.special_cfg  (special_cfg),
		.screen_page  (screen_page)
	);

	mem_map u_mem_map (
		.addr         (addr),
		.mreq_n       (mreq_n),
		.wr_n         (wr_n),
		.ram_page     (ram_page),
		.rom_sel      (rom_sel),
		.special_mode (special_mode),
		.special_cfg  (special_cfg),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we)
	);

	ula_ports u_ula_ports (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.mreq_n       (mreq_n),
		.ram_dout     (ram_dout),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.joy_mode     (joy_mode),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.cpu_din      (cpu_din),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

endmodule

/* source/zx_pkg.sv */
// Shared widths, machine codes and port decode constants for the bus core
// Memory addresses are 21 bits, with bit 20 selecting the ROM area
// Port masks describe partial decodes, so aliases of each port also hit
package zx_pkg;

	// ========================================
	// Bus and memory widths
	// ========================================
	localparam int ADDR_W     = 16;
	localparam int DATA_W     = 8;
	localparam int RAM_PAGE_W = 6;
	localparam int ROM_SEL_W  = 2;
	localparam int BANK_OFS_W = 14;
	localparam int RAM_ADDR_W = 21;
	localparam int KEY_W      = 5;
	localparam int JOY_W      = 6;

	// ========================================
	// Machine codes
	// ========================================
	localparam int MACH_W = 2;

	localparam logic [MACH_W-1:0] MACH_ZX48  = 2'd0;
	localparam logic [MACH_W-1:0] MACH_ZX128 = 2'd1;
	localparam logic [MACH_W-1:0] MACH_PLUS3 = 2'd2;
	localparam logic [MACH_W-1:0] MACH_P1024 = 2'd3;

	// Joystick emulation modes
	localparam logic [2:0] JOY_KEMPSTON   = 3'd0;
	localparam logic [2:0] JOY_SINCLAIR1  = 3'd1;
	localparam logic [2:0] JOY_SINCLAIR2  = 3'd2;
	localparam logic [2:0] JOY_SINCLAIR12 = 3'd3;
	localparam logic [2:0] JOY_CURSOR     = 3'd4;

	// ========================================
	// Port decode
	// ========================================
	// 7FFD needs A15 and A1 low, and A14 high on the +3
	localparam logic [ADDR_W-1:0] PORT_7FFD_MASK     = 16'h8002;
	localparam logic [ADDR_W-1:0] PORT_7FFD_MATCH    = 16'h0000;
	localparam logic [ADDR_W-1:0] PORT_7FFD_MASK_P3  = 16'hC002;
	localparam logic [ADDR_W-1:0] PORT_7FFD_MATCH_P3 = 16'h4000;
	// 1FFD on A15..A12 = 0001 with A1 low
	localparam logic [ADDR_W-1:0] PORT_1FFD_MASK     = 16'hF002;
	localparam logic [ADDR_W-1:0] PORT_1FFD_MATCH    = 16'h1000;
	// EFF7 on A15..A12 = 1110 with A3 low
	localparam logic [ADDR_W-1:0] PORT_EFF7_MASK     = 16'hF008;
	localparam logic [ADDR_W-1:0] PORT_EFF7_MATCH    = 16'hE000;
	// Kempston only looks at the low six address bits
	localparam logic [5:0]        PORT_KEMPSTON      = 6'h1F;

	// 7FFD byte, bits 7:5 change meaning on the Pentagon 1024
	typedef union packed {
		struct packed {
			logic [1:0] unused;
			logic       lock;
			logic       rom;
			logic       screen;
			logic [2:0] bank;
		} std;
		struct packed {
			logic [1:0] ext_hi;
			logic       ext_lo;
			logic       rom;
			logic       screen;
			logic [2:0] bank;
		} p1024;
	} page7ffd_u;

endpackage

/* testbench/tb_tests.svh */
// Bus tasks, reference models and directed tests for the bus core
// Included inside the testbench module, uses its signals directly

// ========================================
// Bus helpers
// ========================================
task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	check_count = check_count + 1;
	if (exp !== act) begin
		$display("error %s: expected %h, actual %h", name, exp, act);
		error_count = error_count + 1;
	end
endtask

task automatic apply_reset(input logic [MACH_W-1:0] mach);
	@(posedge clk_sys);
	#1;
	machine = mach;
	reset   = 1'b1;
	repeat (4) @(posedge clk_sys);
	#1;
	reset = 1'b0;
endtask

// Drives one bus cycle, samples cpu_din, ram_addr and ram_we in its last clock
task automatic bus_cycle(input logic mem, input logic wr, input logic [15:0] a,
	input logic [7:0] d, output logic [7:0] din, output logic [20:0] ra, output logic we);
	@(posedge clk_sys);
	#1;
	addr     = a;
	cpu_dout = d;
	mreq_n   = ~mem;
	iorq_n   = mem;
	wr_n     = ~wr;
	rd_n     = wr;
	repeat (2) @(posedge clk_sys);
	#1;
	din    = cpu_din;
	ra     = ram_addr;
	we     = ram_we;
	@(posedge clk_sys);
	#1;
	mreq_n = 1'b1;
	iorq_n = 1'b1;
	wr_n   = 1'b1;
	rd_n   = 1'b1;
endtask

task automatic io_write(input logic [15:0] a, input logic [7:0] d);
	logic [7:0]  din;
	logic [20:0] ra;
	logic        we;
	bus_cycle(1'b0, 1'b1, a, d, din, ra, we);
endtask

// Expected memory address, page carries the ROM number in the ROM area
function automatic logic [20:0] mapped_addr(input logic rom, input logic [5:0] page,
	input logic [13:0] ofs);
	if (rom) begin
		return {1'b1, 4'b0000, page[1:0], ofs};
	end
	return {1'b0, page, ofs};
endfunction

task automatic check_slot(input string name, input logic [1:0] slot, input logic rom,
	input logic [5:0] page);
	logic [13:0] ofs;
	logic [7:0]  din;
	logic [20:0] ra;
	logic        we;
	ofs = 14'($urandom);
	bus_cycle(1'b1, 1'b0, {slot, ofs}, 8'h00, din, ra, we);
	compare_value(name, 32'(mapped_addr(rom, page, ofs)), 32'(ra));
endtask

// Keys pressed by the joystick, bit 0 is key 0 or key 1 of the half row
function automatic logic [4:0] joystick_keys(input logic [2:0] mode, input logic [5:0] j0,
	input logic [5:0] j1, input logic [15:0] a);
	logic [4:0] r67890;
	logic [4:0] r12345;
	logic [5:0] jb;
	r67890 = '0;
	r12345 = '0;
	jb = j0 | j1;
	if (mode == JOY_SINCLAIR1 || mode == JOY_SINCLAIR12) begin
		r67890[4] = j0[1];
		r67890[3] = j0[0];
		r67890[2] = j0[2];
		r67890[1] = j0[3];
		r67890[0] = j0[4];
	end
	if (mode == JOY_SINCLAIR2 || mode == JOY_SINCLAIR12) begin
		r12345[0] = j1[1];
		r12345[1] = j1[0];
		r12345[2] = j1[2];
		r12345[3] = j1[3];
		r12345[4] = j1[4];
	end
	if (mode == JOY_CURSOR) begin
		r12345[4] = jb[1];
		r67890[4] = jb[2];
		r67890[3] = jb[3];
		r67890[2] = jb[0];
		r67890[0] = jb[4];
	end
	return (a[12] ? 5'b0 : r67890) | (a[11] ? 5'b0 : r12345);
endfunction

// ========================================
// Directed tests
// ========================================
task automatic zx48_paging;
	logic [7:0]  din;
	logic [20:0] ra;
	logic        we;
	apply_reset(MACH_ZX48);
	check_slot("zx48 slot0", 2'd0, 1'b1, 6'd0);
	check_slot("zx48 slot1", 2'd1, 1'b0, 6'd5);
	check_slot("zx48 slot2", 2'd2, 1'b0, 6'd2);
	check_slot("zx48 slot3", 2'd3, 1'b0, 6'd0);
	io_write(16'h7FFD, 8'h1F);
	check_slot("zx48 7ffd ignored", 2'd3, 1'b0, 6'd0);
	check_slot("zx48 rom kept", 2'd0, 1'b1, 6'd0);
	compare_value("zx48 screen", 32'd0, 32'(screen_page));
	bus_cycle(1'b1, 1'b1, 16'h0000, 8'h55, din, ra, we);
	compare_value("zx48 rom write", 32'd0, 32'(we));
	bus_cycle(1'b1, 1'b1, 16'h4000, 8'h55, din, ra, we);
	compare_value("zx48 ram write", 32'd1, 32'(we));
endtask

task automatic zx128_paging;
	apply_reset(MACH_ZX128);
	io_write(16'h7FFD, 8'h1B);
	check_slot("zx128 bank", 2'd3, 1'b0, 6'd3);
	check_slot("zx128 rom", 2'd0, 1'b1, 6'd1);
	compare_value("zx128 screen", 32'd1, 32'(screen_page));
	io_write(16'h7FFD, 8'h26);
	check_slot("zx128 lock write", 2'd3, 1'b0, 6'd6);
	io_write(16'h7FFD, 8'h01);
	check_slot("zx128 locked", 2'd3, 1'b0, 6'd6);
	apply_reset(MACH_ZX128);
	check_slot("zx128 after reset", 2'd3, 1'b0, 6'd0);
endtask

task automatic plus3_paging;
	apply_reset(MACH_PLUS3);
	io_write(16'h1FFD, 8'h01);
	check_slot("plus3 cfg0 s0", 2'd0, 1'b0, 6'd0);
	check_slot("plus3 cfg0 s3", 2'd3, 1'b0, 6'd3);
	io_write(16'h1FFD, 8'h03);
	check_slot("plus3 cfg1 s0", 2'd0, 1'b0, 6'd4);
	check_slot("plus3 cfg1 s3", 2'd3, 1'b0, 6'd7);
	io_write(16'h1FFD, 8'h05);
	check_slot("plus3 cfg2 s2", 2'd2, 1'b0, 6'd6);
	check_slot("plus3 cfg2 s3", 2'd3, 1'b0, 6'd3);
	io_write(16'h1FFD, 8'h07);
	check_slot("plus3 cfg3 s1", 2'd1, 1'b0, 6'd7);
	check_slot("plus3 cfg3 s3", 2'd3, 1'b0, 6'd3);
	io_write(16'h1FFD, 8'h04);
	io_write(16'h7FFD, 8'h10);
	check_slot("plus3 rom3", 2'd0, 1'b1, 6'd3);
	io_write(16'h1FFD, 8'h00);
	check_slot("plus3 rom1", 2'd0, 1'b1, 6'd1);
endtask

task automatic p1024_paging;
	apply_reset(MACH_P1024);
	// Extended bits come from 7FFD bits 5, 7, 6
	io_write(16'h7FFD, 8'hA3);
	check_slot("p1024 ext bank", 2'd3, 1'b0, 6'd51);
	// Bit 5 clear so the lock is off when EFF7 bit 2 goes high
	io_write(16'h7FFD, 8'h43);
	check_slot("p1024 ext low", 2'd3, 1'b0, 6'd11);
	io_write(16'hEFF7, 8'h04);
	io_write(16'h7FFD, 8'hE1);
	check_slot("p1024 ext held", 2'd3, 1'b0, 6'd9);
	io_write(16'h7FFD, 8'h02);
	check_slot("p1024 locked", 2'd3, 1'b0, 6'd9);
endtask

task automatic ula_port_access;
	logic [7:0]  d;
	logic [7:0]  din;
	logic [20:0] ra;
	logic        we;
	logic [15:0] a;
	logic [4:0]  keys;
	apply_reset(MACH_ZX128);
	d = 8'($urandom);
	io_write(16'h00FE, d);
	compare_value("fe border", 32'(d[2:0]), 32'(border_color));
	compare_value("fe mic", 32'(d[3]), 32'(mic_out));
	compare_value("fe ear", 32'(d[4]), 32'(ear_out));
	for (int mode = 0; mode < 5; mode++) begin
		for (int k = 0; k < 3; k++) begin
			a = (k == 0) ? 16'hE7FE : ((k == 1) ? 16'hF7FE : 16'hEFFE);
			joy_mode   = 3'(mode);
			joystick_0 = 6'($urandom);
			joystick_1 = 6'($urandom);
			key_data   = 5'($urandom);
			tape_in    = 1'($urandom);
			keys = key_data & ~joystick_keys(3'(mode), joystick_0, joystick_1, a);
			bus_cycle(1'b0, 1'b0, a, 8'h00, din, ra, we);
			compare_value("fe read", 32'({1'b1, tape_in | d[4], 1'b1, keys}), 32'(din));
		end
	end
	joy_mode = JOY_KEMPSTON;
	bus_cycle(1'b0, 1'b0, 16'h001F, 8'h00, din, ra, we);
	compare_value("kempston", 32'({2'b00, joystick_0 | joystick_1}), 32'(din));
	joy_mode = JOY_SINCLAIR1;
	bus_cycle(1'b0, 1'b0, 16'h001F, 8'h00, din, ra, we);
	compare_value("kempston off", 32'hFF, 32'(din));
	ram_dout = 8'($urandom);
	bus_cycle(1'b1, 1'b0, 16'h8123, 8'h00, din, ra, we);
	compare_value("mem read", 32'(ram_dout), 32'(din));
	bus_cycle(1'b0, 1'b0, 16'h00FF, 8'h00, din, ra, we);
	compare_value("unused port", 32'hFF, 32'(din));
endtask

/* testbench/tb_zx_bus_core.sv */
// Testbench for the bus core, directed tests live in tb_tests.svh
// Inputs change 1 time unit after the rising clock edge
// Bus cycles hold their strobes for 3 clocks
module tb_zx_bus_core
	import zx_pkg::*;
;

	localparam int CYCLE_LIMIT = 600;
	localparam logic [31:0] SEED = 32'hcab747b8;

	logic                  clk_sys;
	logic                  reset;
	logic [ADDR_W-1:0]     addr;
	logic [DATA_W-1:0]     cpu_dout;
	logic                  mreq_n;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  m1_n;
	logic [MACH_W-1:0]     machine;
	logic [2:0]            joy_mode;
	logic [JOY_W-1:0]      joystick_0;
	logic [JOY_W-1:0]      joystick_1;
	logic [KEY_W-1:0]      key_data;
	logic                  tape_in;
	logic [DATA_W-1:0]     ram_dout;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	logic [DATA_W-1:0]     cpu_din;
	logic                  screen_page;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;

	int error_count;
	int check_count;
	int cycle_count;

	zx_bus_core uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_dout     (cpu_dout),
		.mreq_n       (mreq_n),
		.iorq_n       (iorq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.machine      (machine),
		.joy_mode     (joy_mode),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.ram_dout     (ram_dout),
		.ram_addr     (ram_addr),
		.ram_we       (ram_we),
		.cpu_din      (cpu_din),
		.screen_page  (screen_page),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Run limit, roughly twice the length of all tests
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk_sys);
			cycle_count = cycle_count + 1;
			if (cycle_count >= CYCLE_LIMIT) begin
				$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
				$display("** FAIL **");
				$finish;
			end
		end
	end

	`include "tb_tests.svh"

	initial begin
		error_count = 0;
		check_count = 0;
		reset       = 1'b1;
		addr        = '0;
		cpu_dout    = '0;
		mreq_n      = 1'b1;
		iorq_n      = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		m1_n        = 1'b1;
		machine     = MACH_ZX48;
		joy_mode    = JOY_KEMPSTON;
		joystick_0  = '0;
		joystick_1  = '0;
		key_data    = '1;
		tape_in     = 1'b0;
		ram_dout    = '0;
		void'($urandom(SEED));

		zx48_paging();
		zx128_paging();
		plus3_paging();
		p1024_paging();
		ula_port_access();

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* zx_bus_core.f */
+incdir+testbench
source/zx_pkg.sv
source/bank_regs.sv
source/mem_map.sv
source/ula_ports.sv
source/zx_bus_core.sv
testbench/tb_zx_bus_core.sv
